//--- sim.f
+incdir+.
DecodeTypes.sv
RvBranchDecoder.sv
DecodedBranchResolver.sv
DecodeStage.sv
DecodeUnit.sv
tb_DecodeUnit.sv

//--- Bender.yml
package:
  name: decode_unit

export_include_dirs:
  - .

sources:
  - DecodeTypes.sv
  - RvBranchDecoder.sv
  - DecodedBranchResolver.sv
  - DecodeStage.sv
  - DecodeUnit.sv
  - target: test
    files:
      - tb_DecodeUnit.sv

//--- tb_DecodeUnit.sv
// --------------------------------------
// Decode unit testbench
// Directed branch check and timing tests
// --------------------------------------

`include "decode_config.svh"

module tb_DecodeUnit
    import DecodeTypes::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `DECODE_WIDTH;
    localparam int CYCLE_LIMIT = 2000;  // Tests need under 100 cycles, rest is margin
    localparam int KIND_PLAIN = 0;
    localparam int KIND_BRANCH = 1;
    localparam int KIND_JAL = 2;
    localparam int KIND_JALR = 3;
    localparam int KIND_SERIAL = 4;
    localparam InsnWord ADDI_WORD = 32'h00150513;   // addi a0, a0, 1
    localparam InsnWord JALR_WORD = 32'h000080e7;   // jalr ra, 0(ra)
    localparam InsnWord FENCE_WORD = 32'h0ff0000f;
    localparam InsnWord ECALL_WORD = 32'h00000073;

    logic clk = 1'b0;
    logic arstN, fetchValid, stall, backendFlush;
    logic laneValid[W];
    InsnWord insn[W];
    PcPath pc[W];
    logic predTaken[W];
    PcPath predAddr[W];
    GlobalHistory predHistory[W];
    RasPtr predRasPtr[W];
    PcPath laneImm[W];  // Offset encoded into each lane
    logic outValid[W], outPredTaken[W], insnFlushed[W], insnFlushTriggering[W];
    InsnWord outInsn[W];
    PcPath outPc[W], outPredAddr[W];
    logic redirectValid;
    PcPath recoveredPc;
    GlobalHistory recoveredHistory;
    RasPtr recoveredRasPtr;

    logic expValid[W], expFlushed[W], expTrig[W], expTaken[W];
    PcPath expAddr[W], expPc[W];
    InsnWord expInsn[W];
    logic expRedirect;
    PcPath expRecPc;
    GlobalHistory expRecHist;
    RasPtr expRecRas;
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;

    DecodeUnit dut0 (
        .clk(clk), .arstN(arstN), .fetchValid(fetchValid), .stall(stall),
        .backendFlush(backendFlush), .laneValid(laneValid), .insn(insn), .pc(pc),
        .predTaken(predTaken), .predAddr(predAddr), .predHistory(predHistory),
        .predRasPtr(predRasPtr), .outValid(outValid), .outInsn(outInsn), .outPc(outPc),
        .outPredTaken(outPredTaken), .outPredAddr(outPredAddr), .insnFlushed(insnFlushed),
        .insnFlushTriggering(insnFlushTriggering), .redirectValid(redirectValid),
        .recoveredPc(recoveredPc), .recoveredHistory(recoveredHistory),
        .recoveredRasPtr(recoveredRasPtr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic InsnWord jalWord(PcPath imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic InsnWord branchWord(PcPath imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b001, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic PcPath randomJalOffset();
        logic [20:0] r;
        r = 21'($urandom) & ~21'd1;
        return {{(`PC_WIDTH-21){r[20]}}, r};
    endfunction

    function automatic PcPath randomBranchOffset();
        logic [12:0] r;
        r = 13'($urandom) & ~13'd1;
        return {{(`PC_WIDTH-13){r[12]}}, r};
    endfunction

    function automatic int insnKind(InsnWord w);
        case (w[6:0])
            7'b1101111: return KIND_JAL;
            7'b1100111: return KIND_JALR;
            7'b1100011: return KIND_BRANCH;
            7'b0001111, 7'b1110011: return KIND_SERIAL;
            default: return KIND_PLAIN;
        endcase
    endfunction

    // Reference for the first provably wrong lane
    function automatic void expectGroup();
        logic stop;
        int trig;
        int kind;
        PcPath target;
        PcPath trigTarget;
        stop = 1'b0;
        trig = -1;
        trigTarget = '0;
        for (int i = 0; i < W; i++) begin
            expValid[i] = laneValid[i];
            expFlushed[i] = 1'b0;
            expTrig[i] = 1'b0;
            expTaken[i] = predTaken[i];
            expAddr[i] = predAddr[i];
            expPc[i] = pc[i];
            expInsn[i] = insn[i];
        end
        for (int i = 0; i < W; i++) begin
            kind = insnKind(insn[i]);
            target = pc[i] + PcPath'(4);
            if (kind == KIND_JAL || kind == KIND_BRANCH) begin
                target = pc[i] + laneImm[i];
            end
            if (stop) begin
                // Scan already ended
            end
            else if (!laneValid[i]) begin
                stop = 1'b1;
            end
            else if (kind == KIND_SERIAL || (kind == KIND_PLAIN && predTaken[i])) begin
                trig = i;
                stop = 1'b1;
            end
            else if (kind == KIND_JAL || (kind == KIND_BRANCH && predTaken[i])) begin
                if (predAddr[i] != target) trig = i;
                stop = 1'b1;
            end
            else if (kind == KIND_JALR) begin
                stop = 1'b1;
            end
            if (trig == i) trigTarget = target;
        end
        expRedirect = (trig >= 0);
        expRecPc = trigTarget;
        if (expRedirect) begin
            expRecHist = predHistory[trig];
            expRecRas = predRasPtr[trig];
            expTrig[trig] = 1'b1;
            expTaken[trig] = 1'b1;
            expAddr[trig] = trigTarget;
            for (int j = trig + 1; j < W; j++) begin
                expFlushed[j] = 1'b1;
                expValid[j] = 1'b0;
            end
        end
    endfunction

    task automatic tick(int n);
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    // Fresh group, all lanes invalid, sequential PCs
    task automatic newGroup();
        PcPath base;
        base = PcPath'($urandom) & ~PcPath'(3);
        for (int i = 0; i < W; i++) begin
            laneValid[i] = 1'b0;
            insn[i] = ADDI_WORD;
            pc[i] = base + PcPath'(4 * i);
            predTaken[i] = 1'b0;
            predAddr[i] = pc[i] + PcPath'(4);
            predHistory[i] = GlobalHistory'($urandom);
            predRasPtr[i] = RasPtr'($urandom);
            laneImm[i] = '0;
        end
    endtask

    task automatic setLane(int i, InsnWord word, PcPath imm, logic taken, logic wrongAddr);
        laneValid[i] = 1'b1;
        insn[i] = word;
        laneImm[i] = imm;
        predTaken[i] = taken;
        predAddr[i] = (taken ? pc[i] + imm : pc[i] + PcPath'(4)) + (wrongAddr ? PcPath'(16) : '0);
    endtask

    task automatic sendGroup();
        expectGroup();
        fetchValid = 1'b1;
        @(posedge clk);
        #0.5;
        fetchValid = 1'b0;
    endtask

    task automatic checkValue(string what, int lane, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0.1f ns: %s lane %0d got %h expected %h",
                     $realtime, what, lane, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkOutputs();
        #0.5;  // Outputs settled
        for (int i = 0; i < W; i++) begin
            checkValue("outValid", i, outValid[i], expValid[i]);
            checkValue("insnFlushed", i, insnFlushed[i], expFlushed[i]);
            checkValue("insnFlushTriggering", i, insnFlushTriggering[i], expTrig[i]);
            if (expValid[i]) begin
                checkValue("outInsn", i, outInsn[i], expInsn[i]);
                checkValue("outPc", i, outPc[i], expPc[i]);
                checkValue("outPredTaken", i, outPredTaken[i], expTaken[i]);
                checkValue("outPredAddr", i, outPredAddr[i], expAddr[i]);
            end
        end
        checkValue("redirectValid", 0, redirectValid, expRedirect);
        if (expRedirect) begin
            checkValue("recoveredPc", 0, recoveredPc, expRecPc);
            checkValue("recoveredHistory", 0, recoveredHistory, expRecHist);
            checkValue("recoveredRasPtr", 0, recoveredRasPtr, expRecRas);
        end
    endtask

    task automatic checkIdle();
        #0.5;
        for (int i = 0; i < W; i++) begin
            checkValue("idle outValid", i, outValid[i], 1'b0);
            checkValue("idle insnFlushed", i, insnFlushed[i], 1'b0);
            checkValue("idle insnFlushTriggering", i, insnFlushTriggering[i], 1'b0);
        end
        checkValue("idle redirectValid", 0, redirectValid, 1'b0);
    endtask

    task automatic runGroup();
        sendGroup();
        checkOutputs();
        tick(1);
        checkIdle();  // One group, one output cycle
        tick(1);
    endtask

    task automatic finishTest(string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", name);
        end
        else begin
            failCount++;
            $display("test %s: %0d mismatches", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic testPassThrough();
        PcPath imm;
        newGroup();
        imm = randomBranchOffset();
        setLane(0, ADDI_WORD, '0, 1'b0, 1'b0);
        setLane(1, branchWord(imm), imm, 1'b1, 1'b0);
        runGroup();
        newGroup();
        imm = randomJalOffset();
        setLane(0, jalWord(imm), imm, 1'b1, 1'b0);
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        finishTest("pass-through");
    endtask

    task automatic testPcRelativeMiss();
        PcPath imm;
        newGroup();
        imm = randomJalOffset();
        setLane(0, jalWord(imm), imm, 1'b1, 1'b1);
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        newGroup();
        imm = randomJalOffset();
        setLane(0, jalWord(imm), imm, 1'b0, 1'b0);  // JAL missed by the predictor
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        newGroup();
        imm = randomBranchOffset();
        setLane(0, branchWord(imm), imm, 1'b1, 1'b1);
        setLane(1, branchWord(imm), imm, 1'b1, 1'b0);
        runGroup();
        newGroup();
        imm = randomBranchOffset();
        setLane(0, branchWord(imm), imm, 1'b0, 1'b1);  // Not taken, never checked
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        finishTest("pc-relative miss");
    endtask

    task automatic testCertainMiss();
        PcPath imm;
        newGroup();
        setLane(0, ADDI_WORD, '0, 1'b1, 1'b0);
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        newGroup();
        setLane(0, FENCE_WORD, '0, 1'b0, 1'b0);
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        runGroup();
        newGroup();
        setLane(0, ADDI_WORD, '0, 1'b0, 1'b0);
        setLane(1, ECALL_WORD, '0, 1'b0, 1'b0);
        runGroup();
        newGroup();
        imm = randomJalOffset();
        setLane(0, JALR_WORD, '0, 1'b1, 1'b1);
        setLane(1, jalWord(imm), imm, 1'b1, 1'b1);
        runGroup();
        finishTest("certain miss and JALR");
    endtask

    task automatic testInvalidLanes();
        PcPath imm;
        newGroup();
        setLane(0, ADDI_WORD, '0, 1'b1, 1'b0);
        laneValid[0] = 1'b0;
        runGroup();
        newGroup();
        imm = randomJalOffset();
        setLane(0, ADDI_WORD, '0, 1'b0, 1'b0);
        setLane(1, jalWord(imm), imm, 1'b1, 1'b1);
        laneValid[1] = 1'b0;
        runGroup();
        newGroup();
        imm = randomJalOffset();
        setLane(0, ADDI_WORD, '0, 1'b0, 1'b0);
        setLane(1, jalWord(imm), imm, 1'b1, 1'b1);
        runGroup();
        finishTest("invalid lanes");
    endtask

    task automatic testTiming();
        PcPath imm;
        newGroup();
        imm = randomJalOffset();
        setLane(0, jalWord(imm), imm, 1'b1, 1'b1);
        setLane(1, ADDI_WORD, '0, 1'b0, 1'b0);
        sendGroup();
        stall = 1'b1;
        checkIdle();
        repeat (3) begin
            tick(1);
            checkIdle();
        end
        tick(1);
        stall = 1'b0;
        checkOutputs();  // Redirect right after release
        tick(1);
        checkIdle();
        tick(1);
        newGroup();
        setLane(0, ADDI_WORD, '0, 1'b1, 1'b0);
        sendGroup();
        backendFlush = 1'b1;
        checkIdle();
        tick(1);
        backendFlush = 1'b0;
        checkIdle();
        tick(1);
        newGroup();
        setLane(0, FENCE_WORD, '0, 1'b0, 1'b0);
        sendGroup();
        newGroup();  // Wrong-path group in the redirect cycle
        setLane(0, ADDI_WORD, '0, 1'b0, 1'b0);
        fetchValid = 1'b1;
        checkOutputs();
        tick(1);
        fetchValid = 1'b0;
        checkIdle();
        tick(1);
        finishTest("stall, flush and wrong path");
    endtask

    initial begin
        void'($urandom(32'h2e5a_0eb2));
        arstN = 1'b0;
        fetchValid = 1'b0;
        stall = 1'b0;
        backendFlush = 1'b0;
        newGroup();
        repeat (8) @(posedge clk);
        #0.5;
        arstN = 1'b1;
        checkIdle();
        tick(1);
        finishTest("reset");
        testPassThrough();
        testPcRelativeMiss();
        testCertainMiss();
        testInvalidLanes();
        testTiming();
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- DecodeUnit.sv
// --------------------------------------
// Decode unit top level
// Fetch group in, rename group and fetch
// redirect out
// --------------------------------------

`include "decode_config.svh"

module DecodeUnit
    import DecodeTypes::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         fetchValid,   // Whole-group strobe
    input  logic         stall,        // From rename
    input  logic         backendFlush,
    input  logic         laneValid[`DECODE_WIDTH],
    input  InsnWord      insn[`DECODE_WIDTH],
    input  PcPath        pc[`DECODE_WIDTH],
    input  logic         predTaken[`DECODE_WIDTH],
    input  PcPath        predAddr[`DECODE_WIDTH],
    input  GlobalHistory predHistory[`DECODE_WIDTH],
    input  RasPtr        predRasPtr[`DECODE_WIDTH],
    output logic         outValid[`DECODE_WIDTH],
    output InsnWord      outInsn[`DECODE_WIDTH],
    output PcPath        outPc[`DECODE_WIDTH],
    output logic         outPredTaken[`DECODE_WIDTH],
    output PcPath        outPredAddr[`DECODE_WIDTH],
    output logic         insnFlushed[`DECODE_WIDTH],
    output logic         insnFlushTriggering[`DECODE_WIDTH],
    output logic         redirectValid,  // Back to fetch
    output PcPath        recoveredPc,
    output GlobalHistory recoveredHistory,
    output RasPtr        recoveredRasPtr
);

    DecodeStage decodeStage0 (
        .clk                (clk),
        .arstN              (arstN),
        .fetchValid         (fetchValid),
        .stall              (stall),
        .backendFlush       (backendFlush),
        .laneValid          (laneValid),
        .insn               (insn),
        .pc                 (pc),
        .predTaken          (predTaken),
        .predAddr           (predAddr),
        .predHistory        (predHistory),
        .predRasPtr         (predRasPtr),
        .outValid           (outValid),
        .outInsn            (outInsn),
        .outPc              (outPc),
        .outPredTaken       (outPredTaken),
        .outPredAddr        (outPredAddr),
        .insnFlushed        (insnFlushed),
        .insnFlushTriggering(insnFlushTriggering),
        .redirectValid      (redirectValid),
        .recoveredPc        (recoveredPc),
        .recoveredHistory   (recoveredHistory),
        .recoveredRasPtr    (recoveredRasPtr)
    );

endmodule

//--- DecodeStage.sv
// --------------------------------------
// Decode stage
// Group register plus branch check, sends
// the redirect back to fetch
// --------------------------------------

`include "decode_config.svh"

module DecodeStage
    import DecodeTypes::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         fetchValid,
    input  logic         stall,
    input  logic         backendFlush,
    input  logic         laneValid[`DECODE_WIDTH],
    input  InsnWord      insn[`DECODE_WIDTH],
    input  PcPath        pc[`DECODE_WIDTH],
    input  logic         predTaken[`DECODE_WIDTH],
    input  PcPath        predAddr[`DECODE_WIDTH],
    input  GlobalHistory predHistory[`DECODE_WIDTH],
    input  RasPtr        predRasPtr[`DECODE_WIDTH],
    output logic         outValid[`DECODE_WIDTH],
    output InsnWord      outInsn[`DECODE_WIDTH],
    output PcPath        outPc[`DECODE_WIDTH],
    output logic         outPredTaken[`DECODE_WIDTH],
    output PcPath        outPredAddr[`DECODE_WIDTH],
    output logic         insnFlushed[`DECODE_WIDTH],
    output logic         insnFlushTriggering[`DECODE_WIDTH],
    output logic         redirectValid,
    output PcPath        recoveredPc,
    output GlobalHistory recoveredHistory,
    output RasPtr        recoveredRasPtr
);

    logic            occupied;  // Register holds a live group
    logic            regLaneValid[`DECODE_WIDTH];
    InsnWord         regInsn[`DECODE_WIDTH];
    PcPath           regPc[`DECODE_WIDTH];
    logic            regPredTaken[`DECODE_WIDTH];
    PcPath           regPredAddr[`DECODE_WIDTH];
    GlobalHistory    regPredHistory[`DECODE_WIDTH];
    RasPtr           regPredRasPtr[`DECODE_WIDTH];
    BranchTargetType decTargetType[`DECODE_WIDTH];
    logic            decIsJal[`DECODE_WIDTH];
    PcPath           decDisp[`DECODE_WIDTH];
    logic            resValid[`DECODE_WIDTH];
    logic            resFlushed[`DECODE_WIDTH];
    logic            resTriggering[`DECODE_WIDTH];
    logic            flushTriggered;
    logic            active;
    logic [`DECODE_WIDTH-1:0] trigVec;
    logic [`DECODE_WIDTH-1:0] fetchLaneVec;

    // Redirect cycle drops whatever fetch sends, it is wrong-path
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            occupied <= 1'b0;
        end
        else if (backendFlush) begin
            occupied <= 1'b0;
        end
        else if (!stall) begin
            occupied <= fetchValid && !redirectValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid && !stall) begin
            for (int i = 0; i < `DECODE_WIDTH; i++) begin
                regLaneValid[i]   <= laneValid[i];
                regInsn[i]        <= insn[i];
                regPc[i]          <= pc[i];
                regPredTaken[i]   <= predTaken[i];
                regPredAddr[i]    <= predAddr[i];
                regPredHistory[i] <= predHistory[i];
                regPredRasPtr[i]  <= predRasPtr[i];
            end
        end
    end

    for (genvar g = 0; g < `DECODE_WIDTH; g++) begin : genLane
        RvBranchDecoder branchDecoder (
            .insn        (regInsn[g]),
            .targetType  (decTargetType[g]),
            .isJal       (decIsJal[g]),
            .displacement(decDisp[g])
        );
    end

    DecodedBranchResolver resolver0 (
        .laneValid          (regLaneValid),
        .pc                 (regPc),
        .predTaken          (regPredTaken),
        .predAddr           (regPredAddr),
        .predHistory        (regPredHistory),
        .predRasPtr         (regPredRasPtr),
        .targetType         (decTargetType),
        .isJal              (decIsJal),
        .displacement       (decDisp),
        .outValid           (resValid),
        .outPredTaken       (outPredTaken),
        .outPredAddr        (outPredAddr),
        .insnFlushed        (resFlushed),
        .insnFlushTriggering(resTriggering),
        .flushTriggered     (flushTriggered),
        .recoveredPc        (recoveredPc),
        .recoveredHistory   (recoveredHistory),
        .recoveredRasPtr    (recoveredRasPtr)
    );

    // Group leaves only in a free cycle
    assign active        = occupied && !stall && !backendFlush;
    assign redirectValid = active && flushTriggered;

    always_comb begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            outValid[i]            = active && resValid[i];
            insnFlushed[i]         = active && resFlushed[i];
            insnFlushTriggering[i] = active && resTriggering[i];
            outInsn[i]             = regInsn[i];
            outPc[i]               = regPc[i];
            trigVec[i]             = insnFlushTriggering[i];
            fetchLaneVec[i]        = laneValid[i];
        end
    end

    // Fetch has no ready, it must wait out a stall
    fetchDuringStall: assert property (@(posedge clk) disable iff (!arstN)
        !(fetchValid && stall));

    oneTrigger: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(trigVec));

    // A redirect empties the stage, so it cannot repeat next cycle
    redirectOnce: assert property (@(posedge clk) disable iff (!arstN)
        redirectValid |-> (occupied && !stall) ##1 !redirectValid);

    lanePrefix: assert property (@(posedge clk) disable iff (!arstN)
        fetchValid |-> ((fetchLaneVec & (fetchLaneVec + 1'b1)) == '0));

endmodule

//--- DecodedBranchResolver.sv
// --------------------------------------
// Decode-side branch resolver
// Finds the first lane whose prediction is
// provably wrong and builds the redirect
// --------------------------------------

`include "decode_config.svh"

module DecodedBranchResolver
    import DecodeTypes::*;
(
    input  logic            laneValid[`DECODE_WIDTH],
    input  PcPath           pc[`DECODE_WIDTH],
    input  logic            predTaken[`DECODE_WIDTH],
    input  PcPath           predAddr[`DECODE_WIDTH],
    input  GlobalHistory    predHistory[`DECODE_WIDTH],
    input  RasPtr           predRasPtr[`DECODE_WIDTH],
    input  BranchTargetType targetType[`DECODE_WIDTH],
    input  logic            isJal[`DECODE_WIDTH],
    input  PcPath           displacement[`DECODE_WIDTH],
    output logic            outValid[`DECODE_WIDTH],
    output logic            outPredTaken[`DECODE_WIDTH],
    output PcPath           outPredAddr[`DECODE_WIDTH],
    output logic            insnFlushed[`DECODE_WIDTH],
    output logic            insnFlushTriggering[`DECODE_WIDTH],
    output logic            flushTriggered,
    output PcPath           recoveredPc,
    output GlobalHistory    recoveredHistory,
    output RasPtr           recoveredRasPtr
);

    PcPath    decodedPc[`DECODE_WIDTH];
    logic     addrMismatch[`DECODE_WIDTH];
    LaneIndex checkLane;    // Lane where the scan stopped
    logic     addrCheck;    // Stop lane needs its target compared
    logic     certainMiss;  // Stop lane is wrong whatever predAddr says
    logic     scanDone;

    // Decoded target of every lane
    always_comb begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            if (targetType[i] == BTT_PC_RELATIVE) begin
                decodedPc[i] = pc[i] + displacement[i];
            end
            else begin
                // JALR falls here too, its PC is never used for a redirect
                decodedPc[i] = pc[i] + PcPath'(`INSN_BYTES);
            end
            addrMismatch[i] = (predAddr[i] != decodedPc[i]);
        end
    end

    // Ordered scan over the valid prefix
    always_comb begin
        scanDone    = 1'b0;
        addrCheck   = 1'b0;
        certainMiss = 1'b0;
        checkLane   = '0;
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            if (!scanDone) begin
                if (!laneValid[i]) begin
                    scanDone = 1'b1;  // Nothing valid beyond this lane
                end
                else if (targetType[i] == BTT_NEXT && predTaken[i]) begin
                    // Plain instruction predicted as a taken branch
                    checkLane   = LaneIndex'(i);
                    addrCheck   = 1'b1;
                    certainMiss = 1'b1;
                    scanDone    = 1'b1;
                end
                else if (targetType[i] == BTT_PC_RELATIVE && (isJal[i] || predTaken[i])) begin
                    checkLane = LaneIndex'(i);
                    addrCheck = 1'b1;
                    scanDone  = 1'b1;
                end
                else if (targetType[i] == BTT_INDIRECT_JUMP) begin
                    // Register target, left to execute
                    checkLane = LaneIndex'(i);
                    scanDone  = 1'b1;
                end
                else if (targetType[i] == BTT_SERIALIZED) begin
                    checkLane   = LaneIndex'(i);
                    addrCheck   = 1'b1;
                    certainMiss = 1'b1;
                    scanDone    = 1'b1;
                end
            end
        end
    end

    assign flushTriggered = certainMiss || (addrCheck && addrMismatch[checkLane]);

    // Rewrite trigger lane, drop younger lanes
    always_comb begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            insnFlushed[i]         = flushTriggered && (LaneIndex'(i) > checkLane);
            insnFlushTriggering[i] = flushTriggered && (LaneIndex'(i) == checkLane);
            outValid[i]            = laneValid[i] && !insnFlushed[i];
            if (insnFlushTriggering[i]) begin
                outPredTaken[i] = 1'b1;
                outPredAddr[i]  = decodedPc[i];  // Corrected target
            end
            else begin
                outPredTaken[i] = predTaken[i];
                outPredAddr[i]  = predAddr[i];
            end
        end
    end

    // Checkpoints saved when the stop lane was predicted
    assign recoveredPc      = decodedPc[checkLane];
    assign recoveredHistory = predHistory[checkLane];
    assign recoveredRasPtr  = predRasPtr[checkLane];

endmodule

//--- RvBranchDecoder.sv
// --------------------------------------
// RISC-V branch decoder, one lane
// Target class and PC-relative displacement
// --------------------------------------

`include "decode_config.svh"

module RvBranchDecoder
    import DecodeTypes::*;
(
    input  InsnWord         insn,
    output BranchTargetType targetType,
    output logic            isJal,
    output PcPath           displacement
);

    logic [6:0] opcode;
    logic [20:0] immJ;  // J-type offset, bit 0 always zero
    logic [12:0] immB;  // B-type offset, bit 0 always zero

    assign opcode = insn[6:0];

    // Reassemble the scattered immediate fields
    assign immJ = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    assign immB = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

    assign isJal = (opcode == OPC_JAL);

    always_comb begin
        case (opcode)
            OPC_JAL, OPC_BRANCH: begin
                targetType = BTT_PC_RELATIVE;
            end
            OPC_JALR: begin
                targetType = BTT_INDIRECT_JUMP;
            end
            OPC_MISC_MEM, OPC_SYSTEM: begin
                // Younger lanes are refetched after these
                targetType = BTT_SERIALIZED;
            end
            default: begin
                targetType = BTT_NEXT;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JAL: begin
                displacement = {{(`PC_WIDTH-21){immJ[20]}}, immJ};
            end
            OPC_BRANCH: begin
                displacement = {{(`PC_WIDTH-13){immB[12]}}, immB};
            end
            default: begin
                displacement = '0;  // JALR target is not known here
            end
        endcase
    end

endmodule

//--- DecodeTypes.sv
// --------------------------------------
// Decode types
// Shared vectors, target class and opcodes
// --------------------------------------

`include "decode_config.svh"

package DecodeTypes;

    typedef logic [`PC_WIDTH-1:0] PcPath;           // PC or target address
    typedef logic [31:0] InsnWord;
    typedef logic [`GHIST_WIDTH-1:0] GlobalHistory;
    typedef logic [`RAS_PTR_WIDTH-1:0] RasPtr;

    // At least one bit even for a single lane
    typedef logic [(`DECODE_WIDTH > 1 ? $clog2(`DECODE_WIDTH) : 1)-1:0] LaneIndex;

    // Where control goes after an instruction
    typedef enum logic [1:0] {
        BTT_NEXT          = 2'd0,  // Falls through to pc+4
        BTT_PC_RELATIVE   = 2'd1,  // Conditional branch or JAL
        BTT_INDIRECT_JUMP = 2'd2,  // JALR
        BTT_SERIALIZED    = 2'd3   // FENCE, FENCE.I, SYSTEM
    } BranchTargetType;

    // Base opcodes used by branch resolution
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;  // FENCE and FENCE.I
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage

//--- decode_config.svh
// --------------------------------------
// Decode front-end configuration
// Group width and checkpoint field sizes
// --------------------------------------

`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Lanes per fetch group, 2 or 4
`define DECODE_WIDTH 2

// Program counter width
`define PC_WIDTH 32

// Global history checkpoint width
`define GHIST_WIDTH 10

// Return address stack top pointer width
`define RAS_PTR_WIDTH 4

// No compressed instructions
`define INSN_BYTES 4

`endif
